// File: Makefile
VERILATOR ?= verilator
TOP       := tb_dcache
FILELIST  := build.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
RUN_FLAGS := +verilator+error+limit+100

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) dcache_defines.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(RUN_FLAGS)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
+incdir+.
dcache_pkg.sv
mem_bus_pkg.sv
dcache_sram.sv
dcache_data.sv
dcache_tag.sv
dcache_ctrl.sv
dcache_top.sv
dcache_sva.sv
tb_dcache.sv

// File: dcache_ctrl.sv
`include "dcache_defines.svh"

module dcache_ctrl (
  input  logic                   clk,
  input  logic                   rst_n_i,
  // cpu side
  input  logic                   req_valid_i,
  input  dcache_pkg::cpu_req_t   req_i,
  output logic                   req_ready_o,
  output logic                   rsp_valid_o,
  output dcache_pkg::cpu_rsp_t   rsp_o,
  // memory side
  output logic                   mem_req_valid_o,
  output mem_bus_pkg::mem_req_t  mem_req_o,
  input  logic                   mem_credit_i,
  input  logic                   mem_rsp_valid_i,
  input  mem_bus_pkg::mem_rsp_t  mem_rsp_i,
  // tag array
  output logic [`IDX_LEN-1:0]    index_o,
  output logic [`TAG_LEN-1:0]    addr_tag_o,
  output logic                   meta_we_o,
  output dcache_pkg::line_meta_t meta_o,
  // data array
  output logic [`BLK_LEN-1:0]    blk_addr_o,
  output logic [3:0]             burst_count_o,
  output logic                   allocate_valid_o,
  output logic                   writeback_valid_o,
  output logic                   wen_o,
  output logic [127:0]           line_wdata_o,
  output logic [127:0]           wmask_o,
  input  logic                   hit_i,
  input  dcache_pkg::line_meta_t meta_i,
  input  logic [`XLEN-1:0]       rdata_i,
  input  logic [`XLEN-1:0]       writeback_data_i
);

  import dcache_pkg::*;
  import mem_bus_pkg::*;

  typedef logic [$clog2(`MEM_CREDITS+1)-1:0] credit_t;

  ctrl_state_t         state_q;
  ctrl_state_t         state_d;
  cpu_req_t            req_q;
  logic [3:0]          burst_q;
  credit_t             credit_q;
  logic                rsp_valid_q;
  logic [`XLEN-1:0]    rsp_data_q;
  logic [`TAG_LEN-1:0] req_tag;
  logic [`IDX_LEN-1:0] req_idx;
  logic                last_beat;
  logic                store_hit;
  logic [31:0]         strb_bits;

  assign req_tag   = req_q.addr[`XLEN-1 -: `TAG_LEN];
  assign req_idx   = req_q.addr[`BLK_LEN +: `IDX_LEN];
  assign last_beat = (burst_q == 4'(`LINE_BEATS - 1));
  assign store_hit = (state_q == COMPARE) && hit_i && req_q.we;

  assign req_ready_o = (state_q == IDLE);
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o.rdata = rsp_data_q;

  // never send without a credit
  assign mem_req_valid_o = (state_q inside {WB_CMD, WB_DATA, REFILL_CMD}) && (credit_q != '0);

  always_comb begin
    mem_req_o.kind         = MEM_REFILL_CMD;
    mem_req_o.payload.line = '{tag: req_tag, index: req_idx, pad: '0};
    case (state_q)
      WB_CMD: begin
        mem_req_o.kind                 = MEM_WB_CMD;
        mem_req_o.payload.line.tag     = meta_i.tag;  // victim
      end
      WB_DATA: begin
        mem_req_o.kind         = MEM_WB_DATA;
        mem_req_o.payload.data = writeback_data_i;
      end
      default: ;
    endcase
  end

  assign index_o    = req_idx;
  assign addr_tag_o = req_tag;
  assign blk_addr_o = req_q.addr[`BLK_LEN-1:0];
  assign meta_we_o  = store_hit || (state_q == UPDATE);
  assign meta_o     = '{valid: 1'b1, dirty: (state_q == COMPARE), tag: req_tag};

  assign burst_count_o     = burst_q;
  assign allocate_valid_o  = (state_q == REFILL);
  assign writeback_valid_o = (state_q == WB_CMD) || (state_q == WB_DATA);
  assign wen_o             = store_hit || ((state_q == REFILL) && mem_rsp_valid_i);

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      strb_bits[i*8 +: 8] = {8{req_q.strb[i]}};
    end
    if (state_q == REFILL) begin
      line_wdata_o = {4{mem_rsp_i.data}};
      wmask_o      = 128'(32'hffff_ffff) << {burst_q[1:0], 5'b0};
    end else begin
      line_wdata_o = {4{req_q.wdata}};
      wmask_o      = 128'(strb_bits) << {req_q.addr[3:2], 5'b0};
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:       if (req_valid_i) state_d = LOOKUP;
      LOOKUP:     state_d = COMPARE;
      COMPARE: begin
        if (hit_i) begin
          state_d = IDLE;
        end else if (meta_i.valid && meta_i.dirty) begin
          state_d = WB_CMD;
        end else begin
          state_d = REFILL_CMD;
        end
      end
      WB_CMD:     if (mem_req_valid_o) state_d = WB_DATA;
      WB_DATA:    if (mem_req_valid_o && last_beat) state_d = REFILL_CMD;
      REFILL_CMD: if (mem_req_valid_o) state_d = REFILL;
      REFILL:     if (mem_rsp_valid_i && last_beat) state_d = UPDATE;
      UPDATE:     state_d = LOOKUP;  // replay as a hit
      default:    state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      burst_q     <= '0;
      credit_q    <= credit_t'(`MEM_CREDITS);
      rsp_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      rsp_valid_q <= (state_q == COMPARE) && hit_i;
      if (((state_q == WB_DATA) && mem_req_valid_o) || ((state_q == REFILL) && mem_rsp_valid_i)) begin
        burst_q <= burst_q + 4'd1;  // wraps to zero after the last beat
      end
      case ({mem_req_valid_o, mem_credit_i})
        2'b10:   credit_q <= credit_q - credit_t'(1);
        2'b01:   credit_q <= credit_q + credit_t'(1);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i && req_ready_o) begin
      req_q <= req_i;
    end
    if ((state_q == COMPARE) && hit_i) begin
      rsp_data_q <= rdata_i;  // don't care for stores
    end
  end

endmodule

// File: dcache_data.sv
`include "dcache_defines.svh"

module dcache_data (
  input  logic [`IDX_LEN-1:0] index_i,
  input  logic [`BLK_LEN-1:0] blk_addr_i,
  input  logic [3:0]          burst_count_i,
  input  logic                allocate_valid_i,
  input  logic                writeback_valid_i,
  input  logic                wen_i,
  input  logic [127:0]        line_wdata_i,
  input  logic [127:0]        wmask_i,
  output logic [`XLEN-1:0]    writeback_data_o,
  output logic [`XLEN-1:0]    rdata_o,

  output logic [`IDX_LEN-1:0] sram0_addr_o,
  output logic                sram0_cen_o,
  output logic                sram0_wen_o,
  output logic [127:0]        sram0_wmask_o,
  output logic [127:0]        sram0_wdata_o,
  input  logic [127:0]        sram0_rdata_i,
  output logic [`IDX_LEN-1:0] sram1_addr_o,
  output logic                sram1_cen_o,
  output logic                sram1_wen_o,
  output logic [127:0]        sram1_wmask_o,
  output logic [127:0]        sram1_wdata_o,
  input  logic [127:0]        sram1_rdata_i,
  output logic [`IDX_LEN-1:0] sram2_addr_o,
  output logic                sram2_cen_o,
  output logic                sram2_wen_o,
  output logic [127:0]        sram2_wmask_o,
  output logic [127:0]        sram2_wdata_o,
  input  logic [127:0]        sram2_rdata_i,
  output logic [`IDX_LEN-1:0] sram3_addr_o,
  output logic                sram3_cen_o,
  output logic                sram3_wen_o,
  output logic [127:0]        sram3_wmask_o,
  output logic [127:0]        sram3_wdata_o,
  input  logic [127:0]        sram3_rdata_i
);

  logic [127:0]      bank_q [`BANKS];
  logic [`BANKS-1:0] alloc_sel;
  logic [`BANKS-1:0] hit_sel;
  logic [`BANKS-1:0] bank_wen_n;  // active low
  logic [127:0]      hit_line;
  logic [127:0]      wb_line;

  assign bank_q[0] = sram0_rdata_i;
  assign bank_q[1] = sram1_rdata_i;
  assign bank_q[2] = sram2_rdata_i;
  assign bank_q[3] = sram3_rdata_i;

  // refill picks bank by beat, hit by block offset
  always_comb begin
    for (int b = 0; b < `BANKS; b++) begin
      alloc_sel[b]  = allocate_valid_i && (burst_count_i[3:2] == 2'(b));
      hit_sel[b]    = !allocate_valid_i && !writeback_valid_i && (blk_addr_i[5:4] == 2'(b));
      bank_wen_n[b] = !((alloc_sel[b] || hit_sel[b]) && wen_i);
    end
  end

  assign hit_line = bank_q[blk_addr_i[5:4]];
  assign rdata_o  = hit_line[{blk_addr_i[3:2], 5'b0} +: `XLEN];

  // whole victim line is on the bank outputs during writeback
  assign wb_line          = bank_q[burst_count_i[3:2]];
  assign writeback_data_o = wb_line[{burst_count_i[1:0], 5'b0} +: `XLEN];

  assign sram0_addr_o  = index_i;
  assign sram0_cen_o   = 1'b0;
  assign sram0_wen_o   = bank_wen_n[0];
  assign sram0_wmask_o = ~wmask_i;
  assign sram0_wdata_o = line_wdata_i;

  assign sram1_addr_o  = index_i;
  assign sram1_cen_o   = 1'b0;
  assign sram1_wen_o   = bank_wen_n[1];
  assign sram1_wmask_o = ~wmask_i;
  assign sram1_wdata_o = line_wdata_i;

  assign sram2_addr_o  = index_i;
  assign sram2_cen_o   = 1'b0;
  assign sram2_wen_o   = bank_wen_n[2];
  assign sram2_wmask_o = ~wmask_i;
  assign sram2_wdata_o = line_wdata_i;

  assign sram3_addr_o  = index_i;
  assign sram3_cen_o   = 1'b0;
  assign sram3_wen_o   = bank_wen_n[3];
  assign sram3_wmask_o = ~wmask_i;
  assign sram3_wdata_o = line_wdata_i;

endmodule

// File: dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

`define XLEN 32
// address split: tag | index | offset
`define IDX_LEN 7
`define BLK_LEN 6
`define TAG_LEN 19

`define LINE_BEATS 16  // words per line, one per burst beat
`define BANKS 4
`define MEM_CREDITS 4  // granted by memory after reset

`endif

// File: dcache_pkg.sv
`include "dcache_defines.svh"

package dcache_pkg;

  typedef struct packed {
    logic             we;
    logic [`XLEN-1:0] addr;  // word aligned
    logic [`XLEN-1:0] wdata;
    logic [3:0]       strb;
  } cpu_req_t;

  typedef struct packed {
    logic [`XLEN-1:0] rdata;
  } cpu_rsp_t;

  typedef struct packed {
    logic                valid;
    logic                dirty;
    logic [`TAG_LEN-1:0] tag;
  } line_meta_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    COMPARE,
    WB_CMD,      // victim line address
    WB_DATA,
    REFILL_CMD,
    REFILL,
    UPDATE
  } ctrl_state_t;

endpackage

// File: dcache_sram.sv
`include "dcache_defines.svh"

module dcache_sram (
  input  logic                clk,
  input  logic                cen_n_i,
  input  logic                wen_n_i,
  input  logic [`IDX_LEN-1:0] addr_i,
  input  logic [127:0]        wmask_n_i,
  input  logic [127:0]        wdata_i,
  output logic [127:0]        rdata_o
);

  logic [127:0] mem_q [2**`IDX_LEN];

  always_ff @(posedge clk) begin
    if (!cen_n_i) begin
      if (!wen_n_i) begin
        // bit written where mask is low
        mem_q[addr_i] <= (mem_q[addr_i] & wmask_n_i) | (wdata_i & ~wmask_n_i);
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// File: dcache_sva.sv
`include "dcache_defines.svh"

module dcache_sva (
  input logic                    clk,
  input logic                    rst_n_i,
  input logic                    req_valid_i,
  input dcache_pkg::cpu_req_t    req_i,
  input logic                    req_ready_i,
  input logic                    rsp_valid_i,
  input dcache_pkg::cpu_rsp_t    rsp_i,
  input logic                    mem_req_valid_i,
  input mem_bus_pkg::mem_req_t   mem_req_i,
  input logic                    mem_credit_i,
  input logic                    mem_rsp_valid_i,
  input dcache_pkg::ctrl_state_t state_i
);

  import dcache_pkg::*;
  import mem_bus_pkg::*;

  localparam logic [31:0] FILL = 32'h5a3c_0000;

  logic [31:0]            shadow_q [2**14];
  logic [31:0]            last_addr_q;
  logic                   last_we_q;
  logic [2:0]             outst_q;  // credits in use
  logic [4:0]             beats_q;
  logic                   refill_seen_q;
  logic [`TAG_LEN-1:0]    line_tag_q [2**`IDX_LEN];  // tag of the last refill per set
  logic [2**`IDX_LEN-1:0] line_valid_q;
  logic [2:0]             hit_acc_q;  // accepted hits by age
  logic [`IDX_LEN-1:0]    req_idx;
  logic                   accept;
  logic                   exp_hit;
  logic [31:0]            exp_word;
  int unsigned            err_cnt = 0;

  assign accept   = req_valid_i && req_ready_i;
  assign req_idx  = req_i.addr[`BLK_LEN +: `IDX_LEN];
  assign exp_hit  = line_valid_q[req_idx] &&
                    (line_tag_q[req_idx] == req_i.addr[`XLEN-1 -: `TAG_LEN]);
  assign exp_word = shadow_q[last_addr_q[15:2]];

  always @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 2**14; i++) begin
        shadow_q[14'(i)] <= 32'(i) ^ FILL;
      end
    end else if (accept) begin
      last_addr_q <= req_i.addr;
      last_we_q   <= req_i.we;
      for (int b = 0; b < 4; b++) begin
        if (req_i.we && req_i.strb[b]) begin
          shadow_q[req_i.addr[15:2]][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // a refill command claims its set
  always @(posedge clk) begin
    if (mem_req_valid_i && mem_req_i.kind == MEM_REFILL_CMD) begin
      line_tag_q[mem_req_i.payload.line.index] <= mem_req_i.payload.line.tag;
    end
  end

  always @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      outst_q       <= '0;
      beats_q       <= '0;
      refill_seen_q <= 1'b0;
      line_valid_q  <= '0;
      hit_acc_q     <= '0;
    end else begin
      hit_acc_q <= {hit_acc_q[1:0], accept && exp_hit};
      case ({mem_req_valid_i, mem_credit_i})
        2'b10:   outst_q <= outst_q + 3'd1;
        2'b01:   outst_q <= outst_q - 3'd1;
        default: ;
      endcase
      if (mem_req_valid_i && mem_req_i.kind == MEM_REFILL_CMD) begin
        refill_seen_q                            <= 1'b1;
        beats_q                                  <= '0;
        line_valid_q[mem_req_i.payload.line.index] <= 1'b1;
      end else if (mem_rsp_valid_i) begin
        beats_q <= beats_q + 5'd1;
      end
      if (rsp_valid_i) refill_seen_q <= 1'b0;
    end
  end

  a_reset_outputs: assert property (@(posedge clk)
    $rose(rst_n_i) |-> !rsp_valid_i && !mem_req_valid_i && req_ready_i)
    else begin
      err_cnt++;
      $error("FAILED t=%0t rsp_valid_o/mem_req_valid_o/req_ready_o got %b%b%b exp 001",
             $time, rsp_valid_i, mem_req_valid_i, req_ready_i);
    end

  a_credit_limit: assert property (@(posedge clk) disable iff (!rst_n_i)
    mem_req_valid_i |-> outst_q < 3'(`MEM_CREDITS))
    else begin
      err_cnt++;
      $error("memory request sent at t=%0t with no credit left", $time);
    end

  a_refill_beats: assert property (@(posedge clk) disable iff (!rst_n_i)
    rsp_valid_i && refill_seen_q |-> beats_q == 5'(`LINE_BEATS))
    else begin
      err_cnt++;
      $error("FAILED t=%0t refill beats got %0d exp %0d", $time, beats_q, `LINE_BEATS);
    end

  // hit answers two cycles after the accept cycle, not earlier
  a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
    hit_acc_q != '0 |-> rsp_valid_i == hit_acc_q[2])
    else begin
      err_cnt++;
      $error("FAILED t=%0t rsp_valid_o got %b exp %b", $time, rsp_valid_i, hit_acc_q[2]);
    end

  a_load_data: assert property (@(posedge clk) disable iff (!rst_n_i)
    rsp_valid_i && !last_we_q |-> rsp_i.rdata == exp_word)
    else begin
      err_cnt++;
      $error("FAILED t=%0t rsp_o.rdata got %h exp %h", $time, rsp_i.rdata, exp_word);
    end

  // request held while stalled for a credit
  a_hold_stalled: assert property (@(posedge clk) disable iff (!rst_n_i)
    (state_i inside {WB_CMD, WB_DATA, REFILL_CMD}) && !mem_req_valid_i |=> $stable(mem_req_i))
    else begin
      err_cnt++;
      $error("FAILED t=%0t mem_req_o got %h exp %h", $time, mem_req_i, $past(mem_req_i));
    end

endmodule

bind dcache_top dcache_sva i_dcache_sva (
  .clk,
  .rst_n_i,
  .req_valid_i,
  .req_i,
  .req_ready_i     (req_ready_o),
  .rsp_valid_i     (rsp_valid_o),
  .rsp_i           (rsp_o),
  .mem_req_valid_i (mem_req_valid_o),
  .mem_req_i       (mem_req_o),
  .mem_credit_i,
  .mem_rsp_valid_i,
  .state_i         (i_dcache_ctrl.state_q)
);

// File: dcache_tag.sv
`include "dcache_defines.svh"

module dcache_tag (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic [`IDX_LEN-1:0]    index_i,
  input  logic [`TAG_LEN-1:0]    addr_tag_i,
  input  logic                   meta_we_i,
  input  dcache_pkg::line_meta_t meta_i,
  output dcache_pkg::line_meta_t meta_o,
  output logic                   hit_o
);

  logic [2**`IDX_LEN-1:0] valid_q;
  logic [2**`IDX_LEN-1:0] dirty_q;
  logic [`TAG_LEN-1:0]    tag_q [2**`IDX_LEN];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (meta_we_i) begin
      valid_q[index_i] <= meta_i.valid;
      dirty_q[index_i] <= meta_i.dirty;
    end
  end

  always_ff @(posedge clk) begin
    if (meta_we_i) begin
      tag_q[index_i] <= meta_i.tag;
    end
  end

  // registered read, same latency as the data banks
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      meta_o <= '0;
    end else begin
      meta_o <= '{valid: valid_q[index_i], dirty: dirty_q[index_i], tag: tag_q[index_i]};
    end
  end

  assign hit_o = meta_o.valid && (meta_o.tag == addr_tag_i);

endmodule

// File: dcache_top.sv
`include "dcache_defines.svh"

module dcache_top (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  req_valid_i,
  input  dcache_pkg::cpu_req_t  req_i,
  output logic                  req_ready_o,
  output logic                  rsp_valid_o,
  output dcache_pkg::cpu_rsp_t  rsp_o,
  output logic                  mem_req_valid_o,
  output mem_bus_pkg::mem_req_t mem_req_o,
  input  logic                  mem_credit_i,
  input  logic                  mem_rsp_valid_i,
  input  mem_bus_pkg::mem_rsp_t mem_rsp_i
);

  import dcache_pkg::*;

  logic [`IDX_LEN-1:0] index;
  logic [`TAG_LEN-1:0] addr_tag;
  logic                meta_we;
  line_meta_t          meta_wr;
  line_meta_t          meta_rd;
  logic                hit;
  logic [`BLK_LEN-1:0] blk_addr;
  logic [3:0]          burst_count;
  logic                allocate_valid;
  logic                writeback_valid;
  logic                wen;
  logic [127:0]        line_wdata;
  logic [127:0]        wmask;
  logic [`XLEN-1:0]    rdata;
  logic [`XLEN-1:0]    writeback_data;

  logic [`IDX_LEN-1:0] sram_addr [`BANKS];
  logic [`BANKS-1:0]   sram_cen_n;
  logic [`BANKS-1:0]   sram_wen_n;
  logic [127:0]        sram_wmask_n [`BANKS];
  logic [127:0]        sram_wdata [`BANKS];
  logic [127:0]        sram_rdata [`BANKS];

  dcache_ctrl i_dcache_ctrl (
    .clk,
    .rst_n_i,
    .req_valid_i,
    .req_i,
    .req_ready_o,
    .rsp_valid_o,
    .rsp_o,
    .mem_req_valid_o,
    .mem_req_o,
    .mem_credit_i,
    .mem_rsp_valid_i,
    .mem_rsp_i,
    .index_o           (index),
    .addr_tag_o        (addr_tag),
    .meta_we_o         (meta_we),
    .meta_o            (meta_wr),
    .blk_addr_o        (blk_addr),
    .burst_count_o     (burst_count),
    .allocate_valid_o  (allocate_valid),
    .writeback_valid_o (writeback_valid),
    .wen_o             (wen),
    .line_wdata_o      (line_wdata),
    .wmask_o           (wmask),
    .hit_i             (hit),
    .meta_i            (meta_rd),
    .rdata_i           (rdata),
    .writeback_data_i  (writeback_data)
  );

  dcache_tag i_dcache_tag (
    .clk,
    .rst_n_i,
    .index_i    (index),
    .addr_tag_i (addr_tag),
    .meta_we_i  (meta_we),
    .meta_i     (meta_wr),
    .meta_o     (meta_rd),
    .hit_o      (hit)
  );

  dcache_data i_dcache_data (
    .index_i           (index),
    .blk_addr_i        (blk_addr),
    .burst_count_i     (burst_count),
    .allocate_valid_i  (allocate_valid),
    .writeback_valid_i (writeback_valid),
    .wen_i             (wen),
    .line_wdata_i      (line_wdata),
    .wmask_i           (wmask),
    .writeback_data_o  (writeback_data),
    .rdata_o           (rdata),
    .sram0_addr_o      (sram_addr[0]),
    .sram0_cen_o       (sram_cen_n[0]),
    .sram0_wen_o       (sram_wen_n[0]),
    .sram0_wmask_o     (sram_wmask_n[0]),
    .sram0_wdata_o     (sram_wdata[0]),
    .sram0_rdata_i     (sram_rdata[0]),
    .sram1_addr_o      (sram_addr[1]),
    .sram1_cen_o       (sram_cen_n[1]),
    .sram1_wen_o       (sram_wen_n[1]),
    .sram1_wmask_o     (sram_wmask_n[1]),
    .sram1_wdata_o     (sram_wdata[1]),
    .sram1_rdata_i     (sram_rdata[1]),
    .sram2_addr_o      (sram_addr[2]),
    .sram2_cen_o       (sram_cen_n[2]),
    .sram2_wen_o       (sram_wen_n[2]),
    .sram2_wmask_o     (sram_wmask_n[2]),
    .sram2_wdata_o     (sram_wdata[2]),
    .sram2_rdata_i     (sram_rdata[2]),
    .sram3_addr_o      (sram_addr[3]),
    .sram3_cen_o       (sram_cen_n[3]),
    .sram3_wen_o       (sram_wen_n[3]),
    .sram3_wmask_o     (sram_wmask_n[3]),
    .sram3_wdata_o     (sram_wdata[3]),
    .sram3_rdata_i     (sram_rdata[3])
  );

  for (genvar b = 0; b < `BANKS; b++) begin : g_bank
    dcache_sram i_dcache_sram (
      .clk,
      .cen_n_i   (sram_cen_n[b]),
      .wen_n_i   (sram_wen_n[b]),
      .addr_i    (sram_addr[b]),
      .wmask_n_i (sram_wmask_n[b]),
      .wdata_i   (sram_wdata[b]),
      .rdata_o   (sram_rdata[b])
    );
  end

endmodule

// File: mem_bus_pkg.sv
`include "dcache_defines.svh"

package mem_bus_pkg;

  typedef enum logic [1:0] {
    MEM_REFILL_CMD,
    MEM_WB_CMD,
    MEM_WB_DATA
  } mem_kind_t;

  // line aligned address, offset always zero
  typedef struct packed {
    logic [`TAG_LEN-1:0] tag;
    logic [`IDX_LEN-1:0] index;
    logic [`BLK_LEN-1:0] pad;
  } line_addr_t;

  // commands carry a line address, writeback beats carry data
  typedef union packed {
    line_addr_t       line;
    logic [`XLEN-1:0] data;
  } mem_payload_u;

  typedef struct packed {
    mem_kind_t    kind;
    mem_payload_u payload;
  } mem_req_t;

  typedef struct packed {
    logic [`XLEN-1:0] data;  // one refill beat
  } mem_rsp_t;

endpackage

// File: tb_dcache.sv
`include "dcache_defines.svh"

module tb_dcache;

  import dcache_pkg::*;
  import mem_bus_pkg::*;

  localparam logic [31:0] FILL        = 32'h5a3c_0000;  // same constant in dcache_sva
  localparam int          NUM_OPS     = 16;
  localparam int          MISS_CYCLES = 160;  // writeback + refill with slow credits
  localparam int          TIMEOUT     = NUM_OPS * MISS_CYCLES + 50;

  // {we, byte address}
  localparam logic [32:0] OPS [NUM_OPS] = '{
    33'h0_0000_0040, 33'h1_0000_0044, 33'h0_0000_0044, 33'h1_0000_0048,
    33'h0_0000_2040, 33'h0_0000_0044, 33'h0_0000_0048, 33'h1_0000_2078,
    33'h1_0000_4044, 33'h0_0000_2078, 33'h0_0000_4044, 33'h0_0000_0100,
    33'h1_0000_013c, 33'h0_0000_013c, 33'h1_0000_3ffc, 33'h0_0000_3ffc
  };

  logic      clk             = 1'b0;
  logic      rst_n_i         = 1'b0;
  logic      req_valid_i     = 1'b0;
  cpu_req_t  req_i           = '0;
  logic      req_ready_o;
  logic      rsp_valid_o;
  cpu_rsp_t  rsp_o;
  logic      mem_req_valid_o;
  mem_req_t  mem_req_o;
  logic      mem_credit_i    = 1'b0;
  logic      mem_rsp_valid_i = 1'b0;
  mem_rsp_t  mem_rsp_i       = '0;

  logic [15:0]       lfsr_q = 16'd11043;
  logic [31:0]       mem [2**14];  // 64 KiB of word storage
  int unsigned       cycle_q = 0;
  int unsigned       credit_due [$];
  logic [13:0]       wb_ptr;
  logic [13:0]       refill_ptr;
  int                refill_left = 0;
  logic              credit_nxt = 1'b0;
  logic              rsp_valid_nxt = 1'b0;
  mem_rsp_t          rsp_nxt = '0;

  always #5 clk = ~clk;

  dcache_top i_dcache_top (.*);

  // x^16 + x^14 + x^13 + x^11, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // memory model, looks at the channel mid-cycle
  always @(negedge clk) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 2**14; i++) begin
        mem[14'(i)] = 32'(i) ^ FILL;
      end
    end else begin
      credit_nxt = 1'b0;
      if (credit_due.size() != 0 && credit_due[0] <= cycle_q) begin
        credit_nxt = 1'b1;
        void'(credit_due.pop_front());
      end
      if (mem_req_valid_o) begin
        credit_due.push_back(cycle_q + 1 + rand_bits(2));  // 0..3 cycles late
        case (mem_req_o.kind)
          MEM_WB_CMD: wb_ptr = {mem_req_o.payload.line.tag[2:0], mem_req_o.payload.line.index, 4'b0};
          MEM_WB_DATA: begin
            mem[wb_ptr] = mem_req_o.payload.data;
            wb_ptr      = wb_ptr + 14'd1;
          end
          MEM_REFILL_CMD: begin
            refill_ptr  = {mem_req_o.payload.line.tag[2:0], mem_req_o.payload.line.index, 4'b0};
            refill_left = `LINE_BEATS;
          end
          default: ;
        endcase
      end
      rsp_valid_nxt = 1'b0;
      if (refill_left != 0 && rand_bits(2) != 0) begin  // some gaps between beats
        rsp_valid_nxt = 1'b1;
        rsp_nxt.data  = mem[refill_ptr];
        refill_ptr    = refill_ptr + 14'd1;
        refill_left--;
      end
    end
  end

  always @(posedge clk) begin
    #1;
    mem_credit_i    = credit_nxt;
    mem_rsp_valid_i = rsp_valid_nxt;
    mem_rsp_i       = rsp_nxt;
  end

  always @(posedge clk) begin
    cycle_q++;
    if (cycle_q > TIMEOUT) begin
      $display("** FAIL **");
      $fatal(1, "timeout: the cache stopped answering after %0d cycles", cycle_q);
    end
  end

  always @(negedge clk) begin
    if (i_dcache_top.i_dcache_sva.err_cnt != 0) begin
      $display("** FAIL **");
      $fatal(1, "the bound checker reported an assertion failure");
    end
  end

  // called one unit after a rising edge, returns the same way
  task automatic send_request(input logic we, input logic [31:0] addr);
    cpu_req_t req;
    req.we    = we;
    req.addr  = addr;
    req.wdata = rand_bits(32);
    req.strb  = 4'(rand_bits(4));
    if (req.strb == 4'b0) begin
      req.strb = 4'hf;
    end
    req_valid_i = 1'b1;
    req_i       = req;
    do @(negedge clk); while (!req_ready_o);
    @(posedge clk);
    #1 req_valid_i = 1'b0;
    do @(negedge clk); while (!rsp_valid_o);
    @(posedge clk);
    #1;
  endtask

  initial begin
    repeat (5) @(posedge clk);
    #1 rst_n_i = 1'b1;
    for (int n = 0; n < NUM_OPS; n++) begin
      send_request(OPS[n][32], OPS[n][31:0]);
    end
    repeat (4) @(negedge clk);  // let credits drain
    if (i_dcache_top.i_dcache_sva.err_cnt == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("** FAIL **");
      $fatal(1, "assertion failures were counted by the checker");
    end
  end

endmodule
